// File: verilog.f
+incdir+include
rtl/soc_pkg.sv
rtl/wb_bus_decoder.sv
rtl/bram_wb8.sv
rtl/leds_wb8.sv
rtl/timer_wb8.sv
rtl/prng_wb8.sv
rtl/periph_top.sv
sim/periph_chk.sv
sim/tb_periph_top.sv

// File: Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_periph_top \
		-f verilog.f --Mdir obj_dir -o tb_periph_top

run: compile
	./obj_dir/tb_periph_top +verilator+error+limit+100 | tee $(LOG)
	@grep -q "Finished with no errors" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/tb_periph_top.sv
`timescale 1ns/100ps

`include "soc_settings.svh"

module tb_periph_top import soc_pkg::*; ();

    localparam int          MARGIN     = 4;
    localparam int          ACK_LIMIT  = 16;
    localparam wb_addr_t    TIMER_BASE = {`SOC_TIMER_BASE, 8'h00};
    localparam wb_addr_t    PRNG_BASE  = {`SOC_PRNG_BASE, 8'h00};
    localparam wb_addr_t    LEDS_BASE  = {`SOC_LEDS_BASE, 4'h0};
    localparam logic [31:0] PRNG_SEED  = `SOC_PRNG_SEED;

    logic       clk;
    logic       rst_n_i;
    logic       cyc_i;
    logic       stb_i;
    logic       we_i;
    logic       ack_o;
    logic       irq_o;
    wb_addr_t   adr_i;
    wb_data_t   dat_i;
    wb_data_t   dat_o;
    logic [7:0] leds_o;

    wb_data_t   ram_model [0:(1 << `SOC_RAM_ADDR_BITS) - 1];
    int         errors;
    int         mark;
    int         tests_run;
    int         tests_failed;
    int         bad_latency;

    periph_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // xorshift32 with shifts 13, 17, 5
    function automatic logic [31:0] prng_next(input logic [31:0] s);
        logic [31:0] t;
        t = s ^ (s << 13);
        t = t ^ (t >> 17);
        return t ^ (t << 5);
    endfunction

    function automatic int timer_cycles(input logic [15:0] reload);
        return (int'(reload) + 1) * `SOC_TIMER_PRESCALE;
    endfunction

    task automatic check_data(input string name, input wb_data_t expected, input wb_data_t actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %0t ns: %s expected %02h, got %02h", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %0t ns: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == mark) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    // one classic cycle, stb dropped a falling edge after ack is seen
    task automatic wb_access(input logic write, input wb_addr_t adr, input wb_data_t wdata,
                             output wb_data_t rdata);
        int cycles;
        cycles = 0;
        @(negedge clk);
        cyc_i = 1'b1;
        stb_i = 1'b1;
        we_i  = write;
        adr_i = adr;
        dat_i = wdata;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ack_o && cycles < ACK_LIMIT);
        if (!ack_o) begin
            errors++;
            $display("%0t ns: no ack for address %08h after %0d cycles", $time, adr, cycles);
        end else if (cycles != 1) begin
            bad_latency++;
            $display("%0t ns: ack for address %08h came %0d cycles after the strobe",
                     $time, adr, cycles);
        end
        rdata = dat_o;
        @(negedge clk);
        cyc_i = 1'b0;
        stb_i = 1'b0;
        we_i  = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t wdata);
        wb_data_t ignored;
        wb_access(1'b1, adr, wdata, ignored);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t rdata);
        wb_access(1'b0, adr, 8'h00, rdata);
    endtask

    initial begin
        wb_addr_t    ram_adr [0:31];
        wb_data_t    wdata;
        wb_data_t    rd;
        logic [31:0] prng_state;
        logic [15:0] reload;
        int          cycles;
        int          i;

        void'($urandom(12));
        errors = 0;
        mark = 0;
        tests_run = 0;
        tests_failed = 0;
        bad_latency = 0;
        rst_n_i = 1'b0;
        cyc_i = 1'b0;
        stb_i = 1'b0;
        we_i = 1'b0;
        adr_i = '0;
        dat_i = '0;
        repeat (10) @(negedge clk);
        rst_n_i = 1'b1;

        @(negedge clk);
        check_bit("ack_o", 1'b0, ack_o);
        check_data("leds_o", 8'h00, leds_o);
        check_bit("irq_o", 1'b0, irq_o);
        wb_read(PRNG_BASE, rd);
        check_data("prng byte 0", PRNG_SEED[7:0], rd);
        end_test("reset");

        for (i = 0; i < 32; i++) begin
            ram_adr[i] = wb_addr_t'($urandom_range(0, 255));
            wdata = wb_data_t'($urandom);
            ram_model[ram_adr[i][`SOC_RAM_ADDR_BITS-1:0]] = wdata;
            wb_write(ram_adr[i], wdata);
        end
        for (i = 0; i < 32; i++) begin
            wb_read(ram_adr[i], rd);
            check_data("ram dat_o", ram_model[ram_adr[i][`SOC_RAM_ADDR_BITS-1:0]], rd);
        end
        // page 0x135700 is unclaimed, so this hits a ram alias
        wb_read(32'h1357_0000 + ram_adr[0], rd);
        check_data("ram alias dat_o", ram_model[ram_adr[0][`SOC_RAM_ADDR_BITS-1:0]], rd);
        end_test("ram");

        for (i = 0; i < 4; i++) begin
            wdata = wb_data_t'($urandom);
            wb_write(LEDS_BASE + wb_addr_t'($urandom_range(0, 15)), wdata);
            check_data("leds_o", wdata, leds_o);
            wb_read(LEDS_BASE + wb_addr_t'($urandom_range(0, 15)), rd);
            check_data("leds dat_o", wdata, rd);
        end
        end_test("leds");

        prng_state = $urandom;
        if (prng_state == 32'h0) begin
            prng_state = 32'h1;
        end
        for (i = 0; i < 4; i++) begin
            wb_write(PRNG_BASE + wb_addr_t'(i), prng_state[8*i +: 8]);
        end
        for (i = 0; i < 16; i++) begin
            wb_read(PRNG_BASE, rd);
            check_data("prng byte 0", prng_state[7:0], rd);
            prng_state = prng_next(prng_state);
        end
        wb_read(PRNG_BASE + 32'd3, rd);
        check_data("prng byte 3", prng_state[31:24], rd);
        end_test("prng");

        reload = 16'($urandom_range(2, 20));
        wb_write(TIMER_BASE + wb_addr_t'(TMR_RELOAD_LO), reload[7:0]);
        wb_write(TIMER_BASE + wb_addr_t'(TMR_RELOAD_HI), reload[15:8]);
        wb_write(TIMER_BASE + wb_addr_t'(TMR_CTRL), 8'h03);
        cycles = 0;
        while (!irq_o && cycles < timer_cycles(reload) + MARGIN) begin
            @(negedge clk);
            cycles++;
        end
        if (!irq_o) begin
            errors++;
            $display("%0t ns: irq_o never rose within the timer bound", $time);
        end else if (cycles < timer_cycles(reload) - MARGIN) begin
            errors++;
            $display("%0t ns: irq_o rose after %0d cycles, expected no sooner than %0d",
                     $time, cycles, timer_cycles(reload) - MARGIN);
        end
        wb_read(TIMER_BASE + wb_addr_t'(TMR_STATUS), rd);
        check_data("timer status", 8'h01, rd);
        wb_write(TIMER_BASE + wb_addr_t'(TMR_STATUS), 8'h01);
        check_bit("irq_o", 1'b0, irq_o);
        // counting again, interrupt masked
        wb_write(TIMER_BASE + wb_addr_t'(TMR_CTRL), 8'h01);
        cycles = 0;
        while (!irq_o && cycles < timer_cycles(reload) + MARGIN) begin
            @(negedge clk);
            cycles++;
        end
        check_bit("irq_o", 1'b0, irq_o);
        wb_read(TIMER_BASE + wb_addr_t'(TMR_STATUS), rd);
        check_data("timer status", 8'h01, rd);
        end_test("timer");

        errors = errors + bad_latency;
        end_test("bus timing");

        $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, errors, u_dut.u_chk.fail_count);
        if (errors == 0 && u_dut.u_chk.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: sim/periph_chk.sv
`timescale 1ns/100ps

`include "soc_settings.svh"

module periph_chk import soc_pkg::*; (
    input logic       clk,
    input logic       rst_n_i,
    input logic       cyc_i,
    input logic       stb_i,
    input logic       we_i,
    input wb_addr_t   adr_i,
    input wb_data_t   dat_i,
    input logic       ack_i,
    input logic [7:0] leds_i,
    input logic       irq_i
);

    int ack_stb_fails = 0;
    int ack_twice_fails = 0;
    int reset_fails = 0;
    int irq_fails = 0;
    int fail_count;

    logic ctrl_write;
    logic ie_model;

    assign fail_count = ack_stb_fails + ack_twice_fails + reset_fails + irq_fails;

    // first cycle of a write to the timer ctrl register
    assign ctrl_write = cyc_i && stb_i && we_i && !ack_i
                        && adr_i[31:8] == `SOC_TIMER_BASE && adr_i[1:0] == TMR_CTRL;

    // interrupt enable as last written over the bus
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ie_model <= 1'b0;
        end else if (ctrl_write) begin
            ie_model <= dat_i[1];
        end
    end

    ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
        ack_i |-> (cyc_i && stb_i))
        else begin
            ack_stb_fails++;
            $error("ack_o high without cyc_i and stb_i");
        end

    // slaves answer a strobe once
    ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        ack_i |=> !ack_i)
        else begin
            ack_twice_fails++;
            $error("ack_o high for two cycles in a row");
        end

    outputs_after_reset: assert property (@(posedge clk)
        !rst_n_i |=> (leds_i == 8'h00 && !irq_i))
        else begin
            reset_fails++;
            $error("leds_o or irq_o not cleared by reset");
        end

    irq_masked: assert property (@(posedge clk) disable iff (!rst_n_i)
        !ie_model |-> !irq_i)
        else begin
            irq_fails++;
            $error("irq_o high while the timer interrupt is disabled");
        end

endmodule

bind periph_top periph_chk u_chk (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .cyc_i   (cyc_i),
    .stb_i   (stb_i),
    .we_i    (we_i),
    .adr_i   (adr_i),
    .dat_i   (dat_i),
    .ack_i   (ack_o),
    .leds_i  (leds_o),
    .irq_i   (irq_o)
);

// File: rtl/periph_top.sv
`timescale 1ns/100ps

`include "soc_settings.svh"

module periph_top import soc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       cyc_i,
    input  logic       stb_i,
    input  logic       we_i,
    input  wb_addr_t   adr_i,
    input  wb_data_t   dat_i,
    output wb_data_t   dat_o,
    output logic       ack_o,
    output logic [7:0] leds_o,
    output logic       irq_o
);

    logic     ram_stb;
    logic     timer_stb;
    logic     prng_stb;
    logic     leds_stb;

    wb_data_t ram_dat;
    wb_data_t timer_dat;
    wb_data_t prng_dat;
    wb_data_t leds_dat;

    logic     ram_ack;
    logic     timer_ack;
    logic     prng_ack;
    logic     leds_ack;

    wb_bus_decoder u_decoder (
        .cyc_i       (cyc_i),
        .stb_i       (stb_i),
        .adr_i       (adr_i),
        .ram_stb_o   (ram_stb),
        .timer_stb_o (timer_stb),
        .prng_stb_o  (prng_stb),
        .leds_stb_o  (leds_stb),
        .ram_dat_i   (ram_dat),
        .ram_ack_i   (ram_ack),
        .timer_dat_i (timer_dat),
        .timer_ack_i (timer_ack),
        .prng_dat_i  (prng_dat),
        .prng_ack_i  (prng_ack),
        .leds_dat_i  (leds_dat),
        .leds_ack_i  (leds_ack),
        .dat_o       (dat_o),
        .ack_o       (ack_o)
    );

    // ram aliases across the whole default region
    bram_wb8 #(
        .ADDR_BITS (`SOC_RAM_ADDR_BITS)
    ) u_ram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stb_i   (ram_stb),
        .we_i    (we_i),
        .adr_i   (adr_i[`SOC_RAM_ADDR_BITS-1:0]),
        .dat_i   (dat_i),
        .dat_o   (ram_dat),
        .ack_o   (ram_ack)
    );

    leds_wb8 u_leds (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stb_i   (leds_stb),
        .we_i    (we_i),
        .dat_i   (dat_i),
        .dat_o   (leds_dat),
        .ack_o   (leds_ack),
        .leds_o  (leds_o)
    );

    timer_wb8 u_timer (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stb_i   (timer_stb),
        .we_i    (we_i),
        .adr_i   (adr_i[1:0]),
        .dat_i   (dat_i),
        .dat_o   (timer_dat),
        .ack_o   (timer_ack),
        .irq_o   (irq_o)
    );

    prng_wb8 u_prng (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stb_i   (prng_stb),
        .we_i    (we_i),
        .adr_i   (adr_i[1:0]),
        .dat_i   (dat_i),
        .dat_o   (prng_dat),
        .ack_o   (prng_ack)
    );

endmodule

// File: rtl/prng_wb8.sv
`timescale 1ns/100ps

`include "soc_settings.svh"

module prng_wb8 import soc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       stb_i,
    input  logic       we_i,
    input  logic [1:0] adr_i,
    input  wb_data_t   dat_i,
    output wb_data_t   dat_o,
    output logic       ack_o
);

    logic [31:0] state;
    logic [4:0]  byte_lsb;
    logic        access;

    // one xorshift32 step, zero maps to zero
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign access   = stb_i & ~ack_o;
    assign byte_lsb = {adr_i, 3'b000};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= `SOC_PRNG_SEED;
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
            if (access && we_i) begin
                state[byte_lsb +: 8] <= dat_i;
            end else if (access && adr_i == 2'd0) begin
                // reading byte 0 advances, the old byte goes out
                state <= xorshift32(state);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access && !we_i) begin
            dat_o <= state[byte_lsb +: 8];
        end
    end

endmodule

// File: rtl/timer_wb8.sv
`timescale 1ns/100ps

`include "soc_settings.svh"

module timer_wb8 import soc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       stb_i,
    input  logic       we_i,
    input  logic [1:0] adr_i,
    input  wb_data_t   dat_i,
    output wb_data_t   dat_o,
    output logic       ack_o,
    output logic       irq_o
);

    localparam int PRESCALE = `SOC_TIMER_PRESCALE;
    localparam int PS_BITS  = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    timer_state_e       state;
    timer_reg_e         reg_sel;
    logic [15:0]        reload;
    logic [15:0]        count;
    logic [PS_BITS-1:0] prescale_cnt;
    logic               ctrl_ie;
    logic               expired;
    logic               access;
    logic               wr_en;
    logic               ctrl_wr;
    logic               tick;
    wb_data_t           rd_data;

    assign reg_sel = timer_reg_e'(adr_i);
    assign access  = stb_i & ~ack_o;
    assign wr_en   = access & we_i;
    assign ctrl_wr = wr_en & (reg_sel == TMR_CTRL);
    assign tick    = (state == TMR_RUNNING) && (prescale_cnt == PS_BITS'(PRESCALE - 1));
    assign irq_o   = expired & ctrl_ie;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_o        <= 1'b0;
            state        <= TMR_STOPPED;
            reload       <= 16'h0000;
            count        <= 16'h0000;
            prescale_cnt <= '0;
            ctrl_ie      <= 1'b0;
            expired      <= 1'b0;
        end else begin
            ack_o <= access;
            if (wr_en) begin
                case (reg_sel)
                    TMR_RELOAD_LO: reload[7:0] <= dat_i;
                    TMR_RELOAD_HI: reload[15:8] <= dat_i;
                    TMR_CTRL: begin
                        ctrl_ie <= dat_i[1];
                        if (dat_i[0]) begin
                            state        <= TMR_RUNNING;
                            count        <= reload;
                            prescale_cnt <= '0;
                        end else begin
                            state <= TMR_STOPPED;
                        end
                    end
                    TMR_STATUS: begin
                        // write one to clear
                        if (dat_i[0]) begin
                            expired <= 1'b0;
                        end
                    end
                endcase
            end
            // a ctrl write restarts the count, an expiry beats a clear
            if (state == TMR_RUNNING && !ctrl_wr) begin
                if (tick) begin
                    prescale_cnt <= '0;
                    if (count == 16'h0000) begin
                        expired <= 1'b1;
                        count   <= reload;
                    end else begin
                        count <= count - 16'd1;
                    end
                end else begin
                    prescale_cnt <= prescale_cnt + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (reg_sel)
            TMR_RELOAD_LO: rd_data = reload[7:0];
            TMR_RELOAD_HI: rd_data = reload[15:8];
            TMR_CTRL:      rd_data = {6'b0, ctrl_ie, state == TMR_RUNNING};
            TMR_STATUS:    rd_data = {7'b0, expired};
        endcase
    end

    always_ff @(posedge clk) begin
        if (access && !we_i) begin
            dat_o <= rd_data;
        end
    end

endmodule

// File: rtl/leds_wb8.sv
`timescale 1ns/100ps

module leds_wb8 import soc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       stb_i,
    input  logic       we_i,
    input  wb_data_t   dat_i,
    output wb_data_t   dat_o,
    output logic       ack_o,
    output logic [7:0] leds_o
);

    logic [7:0] leds_q;
    logic       access;

    assign access = stb_i & ~ack_o;
    assign leds_o = leds_q;

    // no address decode, every alias hits the same register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            leds_q <= 8'h00;
            ack_o  <= 1'b0;
        end else begin
            ack_o <= access;
            if (access && we_i) begin
                leds_q <= dat_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access && !we_i) begin
            dat_o <= leds_q;
        end
    end

endmodule

// File: rtl/bram_wb8.sv
`timescale 1ns/100ps

`include "soc_settings.svh"

module bram_wb8 import soc_pkg::*; #(
    parameter int ADDR_BITS = `SOC_RAM_ADDR_BITS
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 stb_i,
    input  logic                 we_i,
    input  logic [ADDR_BITS-1:0] adr_i,
    input  wb_data_t             dat_i,
    output wb_data_t             dat_o,
    output logic                 ack_o
);

    wb_data_t mem [0:(1 << ADDR_BITS) - 1];
    logic     access;

    // one access per strobe
    assign access = stb_i & ~ack_o;

    always_ff @(posedge clk) begin
        if (access) begin
            if (we_i) begin
                mem[adr_i] <= dat_i;
            end
            dat_o <= mem[adr_i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

endmodule

// File: rtl/wb_bus_decoder.sv
`timescale 1ns/100ps

`include "soc_settings.svh"

module wb_bus_decoder import soc_pkg::*; (
    input  logic     cyc_i,
    input  logic     stb_i,
    input  wb_addr_t adr_i,

    output logic     ram_stb_o,
    output logic     timer_stb_o,
    output logic     prng_stb_o,
    output logic     leds_stb_o,

    input  wb_data_t ram_dat_i,
    input  logic     ram_ack_i,
    input  wb_data_t timer_dat_i,
    input  logic     timer_ack_i,
    input  wb_data_t prng_dat_i,
    input  logic     prng_ack_i,
    input  wb_data_t leds_dat_i,
    input  logic     leds_ack_i,

    output wb_data_t dat_o,
    output logic     ack_o
);

    slave_sel_e sel;
    logic       bus_req;

    assign bus_req = cyc_i & stb_i;

    // anything not in a peripheral page falls through to ram
    always_comb begin
        if (adr_i[31:8] == `SOC_TIMER_BASE) begin
            sel = SEL_TIMER;
        end else if (adr_i[31:8] == `SOC_PRNG_BASE) begin
            sel = SEL_PRNG;
        end else if (adr_i[31:4] == `SOC_LEDS_BASE) begin
            sel = SEL_LEDS;
        end else begin
            sel = SEL_RAM;
        end
    end

    assign ram_stb_o   = bus_req & (sel == SEL_RAM);
    assign timer_stb_o = bus_req & (sel == SEL_TIMER);
    assign prng_stb_o  = bus_req & (sel == SEL_PRNG);
    assign leds_stb_o  = bus_req & (sel == SEL_LEDS);

    // return path follows the same select
    always_comb begin
        case (sel)
            SEL_TIMER: begin
                dat_o = timer_dat_i;
                ack_o = timer_ack_i;
            end
            SEL_PRNG: begin
                dat_o = prng_dat_i;
                ack_o = prng_ack_i;
            end
            SEL_LEDS: begin
                dat_o = leds_dat_i;
                ack_o = leds_ack_i;
            end
            default: begin
                dat_o = ram_dat_i;
                ack_o = ram_ack_i;
            end
        endcase
    end

endmodule

// File: rtl/soc_pkg.sv
package soc_pkg;

    // wishbone address and data words
    typedef logic [31:0] wb_addr_t;
    typedef logic [7:0] wb_data_t;

    // decoder targets
    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_TIMER,
        SEL_PRNG,
        SEL_LEDS
    } slave_sel_e;

    // timer register map
    typedef enum logic [1:0] {
        TMR_RELOAD_LO = 2'd0,
        TMR_RELOAD_HI = 2'd1,
        TMR_CTRL      = 2'd2,
        TMR_STATUS    = 2'd3
    } timer_reg_e;

    typedef enum logic {
        TMR_STOPPED = 1'b0,
        TMR_RUNNING = 1'b1
    } timer_state_e;

endpackage

// File: include/soc_settings.svh
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// peripheral pages, matched against the upper address bits
// timer at 0xFFFFFDxx
`define SOC_TIMER_BASE 24'hFFFFFD

// prng at 0xFFFFFExx
`define SOC_PRNG_BASE 24'hFFFFFE

// leds at 0xFFFFFFFx, 16 aliases
`define SOC_LEDS_BASE 28'hFFFFFFF

// byte ram, also answers everything unclaimed
`define SOC_RAM_ADDR_BITS 10

// clock cycles per timer tick
`define SOC_TIMER_PRESCALE 8

// xorshift32 state after reset
`define SOC_PRNG_SEED 32'h2545F491

`endif
